/* project.f */
source/bf_pkg.sv
source/edge_if.sv
source/bf_wb_regs.sv
source/bf_sweep_ctrl.sv
source/bf_relax_pipe.sv
source/bf_path_walker.sv
source/bf_top.sv
testbench/bf_asserts.sv
testbench/tb_bf.sv

/* source/bf_path_walker.sv */
`timescale 1ns/10ps

module bf_path_walker import bf_pkg::*; (
	input logic clk,
	input logic clr,
	input logic start, // new run, path no longer valid
	input logic walk,
	input node_t dest,
	input node_t source,
	output node_t probe_node,
	input dist_t probe_dist,
	input node_t probe_pred,
	output logic path_ready,
	output node_t path_len,
	input node_t path_idx,
	output wb_dat_t path_word
);

	wb_dat_t path_buf [NODE_COUNT];
	logic active;
	node_t cur;
	node_t cnt; // entries stored so far
	logic stop;

	assign probe_node = cur;
	assign path_word = path_buf[path_idx];

	// reached the source, hit an unreachable node, or the buffer is full
	assign stop = (cur == source) || (probe_dist == DIST_INF) ||
		(cnt == node_t'(NODE_COUNT - 1));

	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			active <= 1'b0;
			cur <= '0;
			cnt <= '0;
			path_ready <= 1'b0;
			path_len <= '0;
		end else if (walk) begin
			active <= 1'b1;
			cur <= dest;
			cnt <= '0;
			path_ready <= 1'b0;
		end else if (start) begin
			active <= 1'b0;
			path_ready <= 1'b0;
		end else if (active) begin
			if (stop) begin
				active <= 1'b0;
				path_ready <= 1'b1;
				path_len <= cnt + 1'b1;
			end else begin
				cur <= probe_pred; // one hop toward the source
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active)
			path_buf[cnt] <= {1'b0, probe_dist, 3'b000, cur};
	end

endmodule

/* source/bf_pkg.sv */
package bf_pkg;

	localparam int NODE_COUNT = 32;
	localparam int EDGE_DEPTH = 32;
	localparam int PIPE_DRAIN = 3; // edge issue to write-back

	typedef logic [4:0] node_t;
	typedef logic [3:0] weight_t;
	typedef logic [6:0] dist_t;
	typedef logic [4:0] edge_idx_t;
	typedef logic [7:0] wb_adr_t;
	typedef logic [15:0] wb_dat_t;
	typedef logic [13:0] edge_word_t; // weight, from, to

	localparam dist_t DIST_INF = 7'd127; // unreachable, also the saturation value

	// edge word fields
	localparam int EDGE_TO_LSB = 0;
	localparam int EDGE_FROM_LSB = 5;
	localparam int EDGE_WEIGHT_LSB = 10;

	// register map
	localparam wb_adr_t ADR_EDGE_BASE = 8'h00;
	localparam wb_adr_t ADR_SOURCE = 8'h20;
	localparam wb_adr_t ADR_DEST = 8'h21;
	localparam wb_adr_t ADR_STATUS = 8'h22;
	localparam wb_adr_t ADR_PATH_BASE = 8'h40;

	typedef enum logic [2:0] {
		IDLE,
		INIT,
		SWEEP,
		DRAIN,
		DONE
	} sweep_state_t;

endpackage

/* source/bf_relax_pipe.sv */
`timescale 1ns/10ps

module bf_relax_pipe import bf_pkg::*; (
	input logic clk,
	input logic clr,
	edge_if.pipe edges,
	input node_t source,
	input logic init,
	output logic updated,
	input node_t probe_node,
	output dist_t probe_dist,
	output node_t probe_pred
);

	dist_t dist_mem [NODE_COUNT];
	node_t pred_mem [NODE_COUNT];

	logic s1_valid; // registered edge
	node_t s1_src;
	node_t s1_dst;
	weight_t s1_weight;

	logic s2_valid; // operands and sum
	node_t s2_src;
	node_t s2_dst;
	dist_t s2_from;
	dist_t s2_to;
	dist_t s2_sum;

	logic s3_wr; // write-back
	node_t s3_src;
	node_t s3_dst;
	dist_t s3_sum;

	dist_t from_d;
	dist_t to_d;
	logic [7:0] raw_sum;
	logic s2_lower;

	// operand read, newest in-flight value wins
	always_comb begin
		from_d = dist_mem[s1_src];
		to_d = dist_mem[s1_dst];
		if (s3_wr && s3_dst == s1_src)
			from_d = s3_sum;
		if (s3_wr && s3_dst == s1_dst)
			to_d = s3_sum;
		if (s2_lower && s2_dst == s1_src)
			from_d = s2_sum;
		if (s2_lower && s2_dst == s1_dst)
			to_d = s2_sum;
	end

	assign raw_sum = {1'b0, from_d} + {4'b0000, s1_weight};
	assign s2_lower = s2_valid && (s2_from != DIST_INF) && (s2_sum < s2_to);
	assign updated = s3_wr;
	assign probe_dist = dist_mem[probe_node];
	assign probe_pred = pred_mem[probe_node];

	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_wr <= 1'b0;
		end else begin
			s1_valid <= edges.valid;
			s2_valid <= s1_valid;
			s3_wr <= s2_lower;
		end
	end

	always_ff @(posedge clk) begin
		s1_src <= edges.src;
		s1_dst <= edges.dst;
		s1_weight <= edges.weight;
		s2_src <= s1_src;
		s2_dst <= s1_dst;
		s2_from <= from_d;
		s2_to <= to_d;
		s2_sum <= (raw_sum >= {1'b0, DIST_INF}) ? DIST_INF : raw_sum[6:0]; // saturate
		s3_src <= s2_src;
		s3_dst <= s2_dst;
		s3_sum <= s2_sum;
	end

	// distance and predecessor files
	always_ff @(posedge clk) begin
		if (init) begin
			for (int i = 0; i < NODE_COUNT; i++) begin
				dist_mem[i] <= (node_t'(i) == source) ? dist_t'(0) : DIST_INF;
				pred_mem[i] <= node_t'(i); // every node points to itself
			end
		end else if (s3_wr) begin
			dist_mem[s3_dst] <= s3_sum;
			pred_mem[s3_dst] <= s3_src;
		end
	end

endmodule

/* source/bf_sweep_ctrl.sv */
`timescale 1ns/10ps

module bf_sweep_ctrl import bf_pkg::*; (
	input logic clk,
	input logic clr,
	edge_if.sweep edges,
	input logic start,
	output logic init,
	input logic updated,
	output logic busy,
	output logic run_done
);

	sweep_state_t state;
	edge_idx_t idx;
	logic [1:0] drain_cnt;
	logic [4:0] pass_cnt; // completed passes
	logic changed;
	logic more;

	assign edges.idx = idx;
	// the end marker itself is never issued
	assign edges.valid = (state == SWEEP) &&
		!(edges.last && idx != edge_idx_t'(EDGE_DEPTH - 1));
	assign init = state == INIT;
	assign busy = state inside {INIT, SWEEP, DRAIN};
	assign run_done = state == DONE;

	// early stop, or Bellman-Ford pass limit reached
	assign more = (changed || updated) && (pass_cnt < 5'(NODE_COUNT - 2));

	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			state <= IDLE;
			idx <= '0;
			drain_cnt <= '0;
			pass_cnt <= '0;
			changed <= 1'b0;
		end else begin
			case (state)
				IDLE, DONE: begin
					if (start)
						state <= INIT;
				end
				INIT: begin
					idx <= '0;
					pass_cnt <= '0;
					changed <= 1'b0;
					state <= SWEEP;
				end
				SWEEP: begin
					changed <= changed | updated;
					drain_cnt <= '0;
					if (edges.last)
						state <= DRAIN;
					else
						idx <= idx + 1'b1;
				end
				DRAIN: begin
					changed <= changed | updated;
					drain_cnt <= drain_cnt + 1'b1;
					if (drain_cnt == 2'(PIPE_DRAIN - 1)) begin
						// last write-back of the pass lands this cycle
						idx <= '0;
						changed <= 1'b0;
						pass_cnt <= pass_cnt + 1'b1;
						state <= more ? SWEEP : DONE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* source/bf_top.sv */
`timescale 1ns/10ps

module bf_top import bf_pkg::*; (
	input logic clk,
	input logic clr,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_adr_t wb_adr,
	input wb_dat_t wb_dat_w,
	output wb_dat_t wb_dat_r,
	output logic wb_ack
);

	edge_if edges ();

	logic start;
	logic walk;
	logic init;
	logic updated;
	logic busy;
	logic run_done;
	logic path_ready;
	node_t source;
	node_t dest;
	node_t probe_node;
	node_t probe_pred;
	node_t path_len;
	node_t path_idx;
	dist_t probe_dist;
	wb_dat_t path_word;

	// input side
	bf_wb_regs regs0 (
		.clk(clk), .clr(clr),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.tbl(edges.tbl),
		.start(start), .source(source), .walk(walk), .dest(dest),
		.busy(busy), .run_done(run_done),
		.path_ready(path_ready), .path_len(path_len),
		.path_idx(path_idx), .path_word(path_word)
	);

	bf_sweep_ctrl ctrl0 (
		.clk(clk), .clr(clr), .edges(edges.sweep), .start(start), .init(init),
		.updated(updated), .busy(busy), .run_done(run_done)
	);

	bf_relax_pipe pipe0 (
		.clk(clk), .clr(clr), .edges(edges.pipe), .source(source), .init(init),
		.updated(updated), .probe_node(probe_node), .probe_dist(probe_dist),
		.probe_pred(probe_pred)
	);

	// output side
	bf_path_walker walker0 (
		.clk(clk), .clr(clr), .start(start), .walk(walk), .dest(dest), .source(source),
		.probe_node(probe_node), .probe_dist(probe_dist), .probe_pred(probe_pred),
		.path_ready(path_ready), .path_len(path_len),
		.path_idx(path_idx), .path_word(path_word)
	);

endmodule

/* source/bf_wb_regs.sv */
`timescale 1ns/10ps

module bf_wb_regs import bf_pkg::*; (
	input logic clk,
	input logic clr,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_adr_t wb_adr,
	input wb_dat_t wb_dat_w,
	output wb_dat_t wb_dat_r,
	output logic wb_ack,
	edge_if.tbl tbl,
	output logic start,
	output node_t source,
	output logic walk,
	output node_t dest,
	input logic busy,
	input logic run_done,
	input logic path_ready,
	input node_t path_len,
	output node_t path_idx,
	input wb_dat_t path_word
);

	edge_word_t edge_mem [EDGE_DEPTH];
	edge_word_t cur_word;
	logic req;
	logic wr_req;
	logic in_edges;
	logic in_path;
	logic src_ok;
	logic dst_ok;
	wb_dat_t status_word;
	wb_dat_t rd_mux;

	assign req = wb_cyc && wb_stb && !wb_ack; // first cycle of a transfer only
	assign wr_req = req && wb_we;
	assign in_edges = (wb_adr & 8'hE0) == ADR_EDGE_BASE;
	assign in_path = (wb_adr & 8'hE0) == ADR_PATH_BASE;
	assign src_ok = wr_req && (wb_adr == ADR_SOURCE) && !busy;
	assign dst_ok = wr_req && (wb_adr == ADR_DEST) && run_done;
	assign path_idx = wb_adr[4:0];

	// entry under the sweep index
	assign cur_word = edge_mem[tbl.idx];
	assign tbl.dst = cur_word[EDGE_TO_LSB +: $bits(node_t)];
	assign tbl.src = cur_word[EDGE_FROM_LSB +: $bits(node_t)];
	assign tbl.weight = cur_word[EDGE_WEIGHT_LSB +: $bits(weight_t)];
	assign tbl.last = (cur_word == '0) || (tbl.idx == edge_idx_t'(EDGE_DEPTH - 1));

	assign status_word = {3'b000, path_len, 5'b00000, path_ready, run_done, busy};

	always_comb begin
		rd_mux = '0;
		if (in_edges)
			rd_mux = wb_dat_t'(edge_mem[wb_adr[4:0]]);
		else if (in_path)
			rd_mux = path_word;
		else if (wb_adr == ADR_STATUS)
			rd_mux = status_word;
	end

	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			walk <= 1'b0;
			source <= '0;
			dest <= '0;
		end else begin
			wb_ack <= req;
			start <= src_ok; // lines up with the ack
			walk <= dst_ok;
			if (src_ok)
				source <= wb_dat_w[4:0];
			if (dst_ok)
				dest <= wb_dat_w[4:0];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_req && in_edges)
			edge_mem[wb_adr[4:0]] <= wb_dat_w[$bits(edge_word_t)-1:0];
		if (req)
			wb_dat_r <= rd_mux; // held through the ack cycle
	end

endmodule

/* source/edge_if.sv */
`timescale 1ns/10ps

// edge stream from the table through the sweep controller into the pipeline
interface edge_if import bf_pkg::*; ();

	edge_idx_t idx;
	logic valid;
	node_t src;
	node_t dst;
	weight_t weight;
	logic last; // zero word or final slot

	modport tbl (input idx, output src, output dst, output weight, output last);
	modport sweep (output idx, output valid, input last);
	modport pipe (input valid, input src, input dst, input weight);

endinterface

/* testbench/bf_asserts.sv */
`timescale 1ns/10ps

module bf_asserts (
	input logic clk,
	input logic clr,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic busy,
	input logic path_ready
);

	int fail_cnt = 0; // failed assertions so far

	// an ack answers a strobe seen one cycle earlier
	ack_follows_req: assert property (@(posedge clk) disable iff (clr)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			fail_cnt++;
			$error("wb_ack raised without cyc and stb in the cycle before");
		end

	single_ack: assert property (@(posedge clk) disable iff (clr) wb_ack |=> !wb_ack)
		else begin
			fail_cnt++;
			$error("wb_ack high two cycles in a row");
		end

	// a new run throws away the old path
	run_or_path: assert property (@(posedge clk) disable iff (clr) !(busy && path_ready))
		else begin
			fail_cnt++;
			$error("busy and path_ready high together");
		end

endmodule

bind bf_top bf_asserts asserts0 (
	.clk(clk), .clr(clr), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
	.busy(busy), .path_ready(path_ready)
);

/* testbench/tb_bf.sv */
`timescale 1ns/10ps

module tb_bf import bf_pkg::*; ();

	localparam int NROWS = 55;
	localparam int CHAIN_LEN = 20; // edges in the chain graph
	localparam int ACK_LIMIT = 20;
	localparam int POLL_LIMIT = 400;
	localparam int WATCHDOG_CYCLES = NROWS * 200 + CHAIN_LEN * 40;

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_WAIT} op_t;

	typedef struct packed {
		op_t op;
		wb_adr_t adr;
		wb_dat_t dat; // write data, or status mask for OP_WAIT
		wb_dat_t exp;
	} row_t;

	// graph edges 2->3 w1, 1->2 w2, 0->1 w3, 0->5 w9, 0->4 w2, 4->5 w3, 5->6 w4, 3->6 w1
	// path rows hold {distance, node} as read at 0x40 + k
	localparam row_t ROWS [NROWS] = '{
		'{OP_RD, ADR_STATUS, 16'h0000, 16'h0000},
		'{OP_WR, 8'h00, 16'h0443, 16'h0000},
		'{OP_WR, 8'h01, 16'h0822, 16'h0000},
		'{OP_WR, 8'h02, 16'h0C01, 16'h0000},
		'{OP_WR, 8'h03, 16'h2405, 16'h0000},
		'{OP_WR, 8'h04, 16'h0804, 16'h0000},
		'{OP_WR, 8'h05, 16'h0C85, 16'h0000},
		'{OP_WR, 8'h06, 16'h10A6, 16'h0000},
		'{OP_WR, 8'h07, 16'h0466, 16'h0000},
		'{OP_WR, 8'h08, 16'h0000, 16'h0000}, // end marker
		'{OP_RD, 8'h00, 16'h0000, 16'h0443},
		'{OP_RD, 8'h01, 16'h0000, 16'h0822},
		'{OP_RD, 8'h02, 16'h0000, 16'h0C01},
		'{OP_RD, 8'h03, 16'h0000, 16'h2405},
		'{OP_RD, 8'h04, 16'h0000, 16'h0804},
		'{OP_RD, 8'h05, 16'h0000, 16'h0C85},
		'{OP_RD, 8'h06, 16'h0000, 16'h10A6},
		'{OP_RD, 8'h07, 16'h0000, 16'h0466},
		'{OP_RD, 8'h08, 16'h0000, 16'h0000},
		'{OP_WR, ADR_SOURCE, 16'h0000, 16'h0000},
		'{OP_WAIT, ADR_STATUS, 16'h0002, 16'h0000},
		'{OP_WR, ADR_DEST, 16'h0006, 16'h0000},
		'{OP_WAIT, ADR_STATUS, 16'h0004, 16'h0000},
		'{OP_RD, ADR_STATUS, 16'h0000, 16'h0506},
		'{OP_RD, 8'h40, 16'h0000, 16'h0706},
		'{OP_RD, 8'h41, 16'h0000, 16'h0603},
		'{OP_RD, 8'h42, 16'h0000, 16'h0502},
		'{OP_RD, 8'h43, 16'h0000, 16'h0301},
		'{OP_RD, 8'h44, 16'h0000, 16'h0000},
		'{OP_WR, ADR_DEST, 16'h0005, 16'h0000},
		'{OP_WAIT, ADR_STATUS, 16'h0004, 16'h0000},
		'{OP_RD, ADR_STATUS, 16'h0000, 16'h0306},
		'{OP_RD, 8'h40, 16'h0000, 16'h0505},
		'{OP_RD, 8'h41, 16'h0000, 16'h0204},
		'{OP_RD, 8'h42, 16'h0000, 16'h0000},
		'{OP_WR, ADR_DEST, 16'h0007, 16'h0000}, // unreachable
		'{OP_WAIT, ADR_STATUS, 16'h0004, 16'h0000},
		'{OP_RD, ADR_STATUS, 16'h0000, 16'h0106},
		'{OP_RD, 8'h40, 16'h0000, 16'h7F07},
		'{OP_WR, ADR_DEST, 16'h0000, 16'h0000}, // source itself
		'{OP_WAIT, ADR_STATUS, 16'h0004, 16'h0000},
		'{OP_RD, ADR_STATUS, 16'h0000, 16'h0106},
		'{OP_RD, 8'h40, 16'h0000, 16'h0000},
		'{OP_WR, ADR_SOURCE, 16'h0004, 16'h0000}, // second run from node 4
		'{OP_WAIT, ADR_STATUS, 16'h0002, 16'h0000},
		'{OP_WR, ADR_DEST, 16'h0006, 16'h0000},
		'{OP_WAIT, ADR_STATUS, 16'h0004, 16'h0000},
		'{OP_RD, ADR_STATUS, 16'h0000, 16'h0306},
		'{OP_RD, 8'h40, 16'h0000, 16'h0706},
		'{OP_RD, 8'h41, 16'h0000, 16'h0305},
		'{OP_RD, 8'h42, 16'h0000, 16'h0004},
		'{OP_WR, ADR_DEST, 16'h0001, 16'h0000}, // was reachable in the first run
		'{OP_WAIT, ADR_STATUS, 16'h0004, 16'h0000},
		'{OP_RD, ADR_STATUS, 16'h0000, 16'h0106},
		'{OP_RD, 8'h40, 16'h0000, 16'h7F01}
	};

	logic clk = 1'b0;
	logic clr;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w;
	wb_dat_t wb_dat_r;
	logic wb_ack;

	int value_errs = 0;
	int other_errs = 0;
	logic [16:0] lfsr = 17'd78441;

	bf_top dut0 (
		.clk(clk), .clr(clr), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	always #5 clk = ~clk;

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic check_dist(input dist_t got, input dist_t exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s distance %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_node(input node_t got, input node_t exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s gave %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input wb_dat_t got, input wb_dat_t exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s gave %04h, expected %04h", $time, what, got, exp);
		end
	endtask

	// one classic cycle with inputs changed on the falling edge
	task automatic bus_xfer(input logic we, input wb_adr_t adr, input wb_dat_t dat,
		output wb_dat_t rd);
		int n;
		n = 0;
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < ACK_LIMIT);
		rd = wb_dat_r;
		if (!wb_ack) begin
			other_errs++;
			$display("no ack from the DUT for address %02h", adr);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat);
		wb_dat_t unused;
		bus_xfer(1'b1, adr, dat, unused);
	endtask

	task automatic bus_read(input wb_adr_t adr, output wb_dat_t rd);
		bus_xfer(1'b0, adr, '0, rd);
	endtask

	task automatic wait_status(input wb_dat_t mask);
		wb_dat_t st;
		int polls;
		polls = 0;
		do begin
			bus_read(ADR_STATUS, st);
			polls++;
		end while ((st & mask) == '0 && polls < POLL_LIMIT);
		if ((st & mask) == '0) begin
			other_errs++;
			$display("status bit %04h never came up after %0d polls", mask, polls);
		end
	endtask

	// chain 0->1->...->CHAIN_LEN stored back to front
	task automatic run_chain();
		dist_t exp_d [CHAIN_LEN + 1];
		weight_t w;
		wb_dat_t rd;
		node_t exp_len;
		int sum;
		sum = 0;
		exp_d[0] = '0;
		for (int k = 0; k < CHAIN_LEN; k++) begin
			for (int b = 0; b < $bits(weight_t); b++) begin
				lfsr = lfsr_next(lfsr);
				w[b] = lfsr[0];
			end
			sum += w;
			exp_d[k + 1] = (sum >= 127) ? DIST_INF : dist_t'(sum);
			bus_write(wb_adr_t'(CHAIN_LEN - 1 - k), {2'b00, w, node_t'(k), node_t'(k + 1)});
		end
		bus_write(wb_adr_t'(CHAIN_LEN), '0);
		bus_write(ADR_SOURCE, '0);
		wait_status(16'h0002);
		for (int k = 0; k <= CHAIN_LEN; k++) begin
			exp_len = (exp_d[k] == DIST_INF) ? node_t'(1) : node_t'(k + 1);
			bus_write(ADR_DEST, wb_dat_t'(k));
			wait_status(16'h0004);
			bus_read(ADR_STATUS, rd);
			check_node(rd[12:8], exp_len, $sformatf("chain node %0d path length", k));
			bus_read(ADR_PATH_BASE, rd);
			check_node(rd[4:0], node_t'(k), $sformatf("chain node %0d first entry", k));
			check_dist(rd[14:8], exp_d[k], $sformatf("chain node %0d", k));
		end
	endtask

	initial begin
		wb_dat_t rd;
		clr = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		clr = 1'b0;
		for (int i = 0; i < NROWS; i++) begin
			case (ROWS[i].op)
				OP_WR: bus_write(ROWS[i].adr, ROWS[i].dat);
				OP_RD: begin
					bus_read(ROWS[i].adr, rd);
					if (ROWS[i].adr >= ADR_PATH_BASE) begin
						check_node(rd[4:0], ROWS[i].exp[4:0], $sformatf("row %0d node", i));
						check_dist(rd[14:8], ROWS[i].exp[14:8], $sformatf("row %0d", i));
					end else begin
						check_word(rd, ROWS[i].exp, $sformatf("row %0d read %02h", i, ROWS[i].adr));
					end
				end
				default: wait_status(ROWS[i].dat);
			endcase
		end
		run_chain();
		$display("value errors: %0d, other errors: %0d, assertion errors: %0d",
			value_errs, other_errs, dut0.asserts0.fail_cnt);
		if (value_errs == 0 && other_errs == 0 && dut0.asserts0.fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule
